// File: eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    localparam int QUARTER_CYCLES = 2;  // CLK cycles per quarter SCL bit
    localparam int QCNT_W = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;
    localparam logic [3:0] DEV_SELECT = 4'b1010;
    localparam int ADDR_W = 11;

    localparam int AXIL_ADDR_W = 32;
    localparam int AXIL_DATA_W = 32;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_CMD = 32'h0;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_STATUS = 32'h4;
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // register field positions
    localparam int CMD_DATA_LSB = 11;
    localparam int CMD_RD_BIT = 31;
    localparam int STAT_DATA_LSB = 8;

    typedef enum logic {op_write_byte, op_read_random} eeprom_op_e;

    typedef enum logic [3:0] {
        st_idle, st_start, st_ctrl_wr, st_word_addr, st_data_wr,
        st_rstart, st_ctrl_rd, st_data_rd, st_stop, st_done
    } seq_state_e;

    typedef enum logic [1:0] {
        bop_start, bop_stop, bop_write_byte, bop_read_byte_nack
    } bit_op_e;

    typedef struct packed {
        eeprom_op_e        op;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } eeprom_cmd_t;

    typedef struct packed {
        logic       nack;
        logic [7:0] rd_data;
    } eeprom_result_t;

    typedef struct packed {
        bit_op_e    op;
        logic [7:0] tx_byte;
    } bit_req_t;

    typedef struct packed {
        logic       done;
        logic       ack_ok;
        logic [7:0] rx_byte;
    } bit_rsp_t;

    typedef struct packed {
        logic                     awvalid;
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     wvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;
        logic                     bready;
        logic                     arvalid;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     rready;
    } axil_req_t;

    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

// File: scl_phase_timer.sv
`timescale 1ns/1ps
`default_nettype none

module scl_phase_timer
    import eeprom_pkg::*;
(
    input  wire        CLK,
    input  wire        RESET,
    input  logic       run,
    output logic       tick,
    output logic [1:0] phase
);

    logic [QCNT_W-1:0] cnt;

    // last cycle of a quarter bit
    assign tick = run && (cnt == QCNT_W'(QUARTER_CYCLES - 1));

    always_ff @(posedge CLK) begin
        if (RESET || !run) begin
            cnt   <= '0;  // idle keeps the timer at phase 0
            phase <= 2'd0;
        end else if (tick) begin
            cnt   <= '0;
            phase <= phase + 2'd1;  // wraps after four quarters
        end else begin
            cnt <= cnt + QCNT_W'(1);
        end
    end

endmodule

`default_nettype wire

// File: i2c_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine
    import eeprom_pkg::*;
(
    input  wire         CLK,
    input  wire         RESET,
    input  logic        req_valid,
    input  bit_req_t    req,
    output bit_rsp_t    rsp,
    output logic        run,
    input  logic        tick,
    input  logic [1:0]  phase,
    input  logic        sda_in,
    output logic        scl_out,
    output logic        sda_pull_low
);

    bit_op_e    op_q;
    logic       busy_q;
    logic       done_q;
    logic       ack_ok_q;
    logic [3:0] bit_cnt;  // 8 is the ack slot
    logic [7:0] shreg;
    logic       scl_q;
    logic       sda_low_q;
    logic       byte_op;

    assign byte_op = (op_q == bop_write_byte) || (op_q == bop_read_byte_nack);

    assign run          = busy_q;
    assign scl_out      = scl_q;
    assign sda_pull_low = sda_low_q;

    assign rsp.done    = done_q;
    assign rsp.ack_ok  = ack_ok_q;
    assign rsp.rx_byte = shreg;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            op_q      <= bop_start;
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            ack_ok_q  <= 1'b0;
            bit_cnt   <= 4'd0;
            scl_q     <= 1'b1;
            sda_low_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!busy_q) begin
                if (req_valid) begin
                    busy_q  <= 1'b1;
                    op_q    <= req.op;
                    bit_cnt <= 4'd0;
                    // values for phase 0 of the first bit
                    case (req.op)
                        bop_start: sda_low_q <= 1'b0;  // scl stays where it is
                        bop_stop: begin
                            scl_q     <= 1'b0;
                            sda_low_q <= 1'b1;
                        end
                        bop_write_byte: begin
                            scl_q     <= 1'b0;
                            sda_low_q <= ~req.tx_byte[7];
                        end
                        default: begin
                            scl_q     <= 1'b0;
                            sda_low_q <= 1'b0;
                        end
                    endcase
                end
            end else if (tick) begin
                case (phase)
                    2'd0: scl_q <= 1'b1;
                    2'd1: begin  // mid-high
                        if (op_q == bop_start) begin
                            sda_low_q <= 1'b1;  // start condition
                        end else if (op_q == bop_stop) begin
                            sda_low_q <= 1'b0;  // stop condition
                        end else if (bit_cnt == 4'd8) begin
                            ack_ok_q <= ~sda_in;
                        end else begin
                            ack_ok_q <= 1'b0;
                        end
                    end
                    2'd2: begin
                        if (op_q != bop_stop) begin
                            scl_q <= 1'b0;
                        end
                    end
                    default: begin
                        if (byte_op && bit_cnt != 4'd8) begin
                            bit_cnt   <= bit_cnt + 4'd1;
                            sda_low_q <= (op_q == bop_write_byte) && (bit_cnt != 4'd7)
                                         && ~shreg[7];
                        end else begin
                            busy_q <= 1'b0;
                            done_q <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // tx bits leave from the top, rx bits enter at the bottom
    always_ff @(posedge CLK) begin
        if (!busy_q && req_valid) begin
            shreg <= req.tx_byte;
        end else if (busy_q && tick && phase == 2'd1 && byte_op && bit_cnt != 4'd8) begin
            shreg <= {shreg[6:0], sda_in};
        end
    end

endmodule

`default_nettype wire

// File: eeprom_seq_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_seq_fsm
    import eeprom_pkg::*;
(
    input  wire            CLK,
    input  wire            RESET,
    input  logic           cmd_valid,
    input  eeprom_cmd_t    cmd,
    output logic           busy,
    output logic           result_valid,
    output eeprom_result_t result,
    output logic           req_valid,
    output bit_req_t       req,
    input  bit_rsp_t       rsp
);

    seq_state_e  state;
    seq_state_e  state_next;
    eeprom_cmd_t cmd_q;
    logic        nack;
    logic [7:0]  rd_data;
    logic        ack_fail;
    logic        wr_state;

    // bus operation for a given state
    function automatic bit_req_t bus_req(seq_state_e s, eeprom_cmd_t c);
        bit_req_t r;
        r.op      = bop_write_byte;
        r.tx_byte = {DEV_SELECT, c.addr[ADDR_W-1:8], 1'b0};
        case (s)
            st_start, st_rstart: r.op = bop_start;
            st_stop:             r.op = bop_stop;
            st_word_addr:        r.tx_byte = c.addr[7:0];
            st_data_wr:          r.tx_byte = c.wdata;
            st_ctrl_rd:          r.tx_byte[0] = 1'b1;  // R/W = read
            st_data_rd:          r.op = bop_read_byte_nack;
            default: ;
        endcase
        return r;
    endfunction

    assign ack_fail = rsp.done && !rsp.ack_ok;
    assign wr_state = (state == st_ctrl_wr) || (state == st_word_addr)
                      || (state == st_data_wr) || (state == st_ctrl_rd);

    always_comb begin
        state_next = state;
        case (state)
            st_idle:  if (cmd_valid) state_next = st_start;
            st_start: if (rsp.done) state_next = st_ctrl_wr;
            st_ctrl_wr: begin
                if (rsp.done) state_next = ack_fail ? st_stop : st_word_addr;
            end
            st_word_addr: begin
                if (ack_fail) begin
                    state_next = st_stop;
                end else if (rsp.done) begin
                    state_next = (cmd_q.op == op_read_random) ? st_rstart : st_data_wr;
                end
            end
            st_data_wr: if (rsp.done) state_next = st_stop;
            st_rstart:  if (rsp.done) state_next = st_ctrl_rd;
            st_ctrl_rd: begin
                if (rsp.done) state_next = ack_fail ? st_stop : st_data_rd;
            end
            st_data_rd: if (rsp.done) state_next = st_stop;
            st_stop:    if (rsp.done) state_next = st_done;
            st_done:    state_next = st_idle;
            default:    state_next = st_idle;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state        <= st_idle;
            busy         <= 1'b0;
            result_valid <= 1'b0;
            req_valid    <= 1'b0;
            nack         <= 1'b0;
            rd_data      <= 8'h00;
        end else begin
            state        <= state_next;
            result_valid <= (state == st_done);
            // every bus state issues exactly one request on entry
            req_valid    <= (state_next != state) && (state_next != st_done)
                            && (state_next != st_idle);
            if (state == st_idle && cmd_valid) begin
                busy <= 1'b1;
                nack <= 1'b0;
            end
            if (state == st_done) begin
                busy <= 1'b0;
            end
            if (wr_state && ack_fail) begin
                nack <= 1'b1;
            end
            if (state == st_data_rd && rsp.done) begin
                rd_data <= rsp.rx_byte;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state == st_idle && cmd_valid) begin
            cmd_q <= cmd;
        end
        req <= bus_req(state_next, (state == st_idle) ? cmd : cmd_q);
    end

    assign result.nack    = nack;
    assign result.rd_data = rd_data;

endmodule

`default_nettype wire

// File: axil_eeprom_regs.sv
`timescale 1ns/1ps
`default_nettype none

module axil_eeprom_regs
    import eeprom_pkg::*;
(
    input  wire            CLK,
    input  wire            RESET,
    input  axil_req_t      axil_req,
    output axil_rsp_t      axil_rsp,
    output logic           cmd_valid,
    output eeprom_cmd_t    cmd,
    input  logic           busy,
    input  logic           result_valid,
    input  eeprom_result_t result
);

    logic                   bvalid_q;
    logic [1:0]             bresp_q;
    logic                   rvalid_q;
    logic [1:0]             rresp_q;
    logic [AXIL_DATA_W-1:0] rdata_q;
    logic                   busy_st;  // set at launch, cleared by the result
    logic                   nack_q;
    logic [7:0]             rd_data_q;
    logic                   wr_fire;
    logic                   rd_fire;
    logic                   launch;
    logic [AXIL_DATA_W-1:0] cmd_word;
    logic [AXIL_DATA_W-1:0] status_word;
    logic [AXIL_DATA_W-1:0] rd_word;
    logic                   rd_ok;

    assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign rd_fire = axil_req.arvalid && !rvalid_q;
    assign launch  = wr_fire && (axil_req.awaddr == ADDR_CMD) && !busy && !busy_st;

    always_comb begin
        cmd_word                           = '0;
        cmd_word[ADDR_W-1:0]               = cmd.addr;
        cmd_word[CMD_DATA_LSB +: 8]        = cmd.wdata;
        cmd_word[CMD_RD_BIT]               = (cmd.op == op_read_random);
        status_word                        = '0;
        status_word[0]                     = busy_st;
        status_word[1]                     = nack_q;
        status_word[STAT_DATA_LSB +: 8]    = rd_data_q;
        rd_word = '0;
        rd_ok   = 1'b1;
        case (axil_req.araddr)
            ADDR_CMD:    rd_word = cmd_word;
            ADDR_STATUS: rd_word = status_word;
            default:     rd_ok = 1'b0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            bvalid_q  <= 1'b0;
            rvalid_q  <= 1'b0;
            cmd_valid <= 1'b0;
            cmd       <= '0;
            busy_st   <= 1'b0;
            nack_q    <= 1'b0;
            rd_data_q <= 8'h00;
        end else begin
            cmd_valid <= launch;
            if (launch) begin
                cmd.op    <= axil_req.wdata[CMD_RD_BIT] ? op_read_random : op_write_byte;
                cmd.addr  <= axil_req.wdata[ADDR_W-1:0];
                cmd.wdata <= axil_req.wdata[CMD_DATA_LSB +: 8];
                busy_st   <= 1'b1;
            end else if (result_valid) begin
                busy_st   <= 1'b0;
                nack_q    <= result.nack;
                rd_data_q <= result.rd_data;
            end
            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_fire) begin
                rvalid_q <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_fire) begin
            if (axil_req.awaddr == ADDR_STATUS) begin
                bresp_q <= RESP_OKAY;  // read-only, write ignored
            end else begin
                bresp_q <= launch ? RESP_OKAY : RESP_SLVERR;
            end
        end
        if (rd_fire) begin
            rdata_q <= rd_word;
            rresp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign axil_rsp.awready = wr_fire;
    assign axil_rsp.wready  = wr_fire;
    assign axil_rsp.bvalid  = bvalid_q;
    assign axil_rsp.bresp   = bresp_q;
    assign axil_rsp.arready = !rvalid_q;
    assign axil_rsp.rvalid  = rvalid_q;
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = rresp_q;

endmodule

`default_nettype wire

// File: eeprom_i2c_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_i2c_top
    import eeprom_pkg::*;
(
    input  wire       CLK,
    input  wire       RESET,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output logic      scl_out,
    output logic      sda_pull_low,
    input  logic      sda_in
);

    logic           cmd_valid;
    eeprom_cmd_t    cmd;
    logic           busy;
    logic           result_valid;
    eeprom_result_t result;
    logic           req_valid;
    bit_req_t       req;
    bit_rsp_t       rsp;
    logic           run;
    logic           tick;
    logic [1:0]     phase;

    axil_eeprom_regs u_axil_eeprom_regs (
        .CLK(CLK), .RESET(RESET), .axil_req(axil_req), .axil_rsp(axil_rsp),
        .cmd_valid(cmd_valid), .cmd(cmd), .busy(busy),
        .result_valid(result_valid), .result(result)
    );

    eeprom_seq_fsm u_eeprom_seq_fsm (
        .CLK(CLK), .RESET(RESET), .cmd_valid(cmd_valid), .cmd(cmd), .busy(busy),
        .result_valid(result_valid), .result(result),
        .req_valid(req_valid), .req(req), .rsp(rsp)
    );

    i2c_bit_engine u_i2c_bit_engine (
        .CLK(CLK), .RESET(RESET), .req_valid(req_valid), .req(req), .rsp(rsp),
        .run(run), .tick(tick), .phase(phase), .sda_in(sda_in),
        .scl_out(scl_out), .sda_pull_low(sda_pull_low)
    );

    scl_phase_timer u_scl_phase_timer (
        .CLK(CLK), .RESET(RESET), .run(run), .tick(tick), .phase(phase)
    );

endmodule

`default_nettype wire

// File: eeprom_bus_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_bus_model
    import eeprom_pkg::*;
(
    input  wire                scl,
    input  wire                sda,
    input  logic               present,
    output logic               pull_low,
    output logic [ADDR_W-1:0]  last_addr,
    output logic [3:0]         bit_pos,
    output logic               ctrl_bad
);

    logic [7:0]        mem [0:2047];
    logic [7:0]        shreg;
    logic [7:0]        rd_byte;
    logic [1:0]        byte_idx;   // 0 control, 1 word address, 2 data
    logic              rd_pending;
    logic              rd_mode;
    logic [ADDR_W-1:0] ptr;
    logic              scl_q;
    logic              sda_q;

    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 8'(i) ^ {3'(i >> 8), 5'b10110};  // every address bit shows up
        end
        pull_low   = 1'b0;
        last_addr  = '0;
        bit_pos    = 4'd0;
        ctrl_bad   = 1'b0;
        shreg      = 8'h00;
        rd_byte    = 8'h00;
        byte_idx   = 2'd0;
        rd_pending = 1'b0;
        rd_mode    = 1'b0;
        ptr        = '0;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
    end

    task automatic take_byte();
        case (byte_idx)
            2'd0: begin
                if (shreg[7:4] != DEV_SELECT) begin
                    ctrl_bad = 1'b1;
                end
                ptr[ADDR_W-1:8] = shreg[3:1];
                rd_pending      = shreg[0];
                if (shreg[0]) begin
                    last_addr = ptr;
                end
            end
            2'd1: begin
                ptr[7:0]  = shreg;
                last_addr = ptr;
            end
            default: mem[ptr] = shreg;
        endcase
        if (byte_idx != 2'd2) begin
            byte_idx = byte_idx + 2'd1;
        end
    endtask

    task automatic on_scl_fall();
        if (rd_mode) begin
            if (bit_pos < 4'd8) begin
                rd_byte  = rd_byte << 1;
                pull_low = ~rd_byte[7];
            end else begin
                pull_low = 1'b0;  // master acks or nacks here
            end
            if (bit_pos == 4'd9) begin
                rd_mode = 1'b0;
                bit_pos = 4'd0;
            end
        end else if (bit_pos == 4'd8) begin
            if (present) begin
                take_byte();
            end
            pull_low = present && !ctrl_bad;
        end else if (bit_pos == 4'd9) begin
            pull_low = 1'b0;
            bit_pos  = 4'd0;
            if (rd_pending) begin
                rd_pending = 1'b0;
                rd_mode    = 1'b1;
                rd_byte    = mem[ptr];
                pull_low   = ~rd_byte[7];
            end
        end
    endtask

    always @(scl, sda) begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q) begin
            // start or stop, both restart the byte framing
            bit_pos    = 4'd0;
            byte_idx   = 2'd0;
            rd_mode    = 1'b0;
            rd_pending = 1'b0;
            pull_low   = 1'b0;
        end else if (scl === 1'b1 && scl_q === 1'b0) begin
            bit_pos = bit_pos + 4'd1;
            if (!rd_mode && bit_pos <= 4'd8) begin
                shreg = {shreg[6:0], sda};
            end
        end else if (scl === 1'b0 && scl_q === 1'b1) begin
            on_scl_fall();
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

`default_nettype wire

// File: tb_eeprom_i2c.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_i2c
    import eeprom_pkg::*;
();

    logic              CLK;
    logic              RESET;
    axil_req_t         axil_req;
    axil_rsp_t         axil_rsp;
    logic              present;
    wire               scl;
    wire               dut_sda_low;
    wire               model_sda_low;
    wire               sda;
    wire [ADDR_W-1:0]  seen_addr;
    wire [3:0]         bit_pos;
    wire               ctrl_bad;

    logic [7:0]        shadow [0:2047];
    logic [ADDR_W-1:0] addrs [16];
    logic [ADDR_W-1:0] addr;
    logic [7:0]        data;
    logic [31:0]       status;
    logic [31:0]       rdata;
    logic [1:0]        resp;
    int                errors;
    int                errors_before;
    int                test_count;
    int                tests_failed;

    assign sda = ~(dut_sda_low | model_sda_low);  // open-drain wired-AND

    eeprom_i2c_top u_eeprom_i2c_top (
        .CLK(CLK), .RESET(RESET), .axil_req(axil_req), .axil_rsp(axil_rsp),
        .scl_out(scl), .sda_pull_low(dut_sda_low), .sda_in(sda)
    );

    eeprom_bus_model u_eeprom_bus_model (
        .scl(scl), .sda(sda), .present(present), .pull_low(model_sda_low),
        .last_addr(seen_addr), .bit_pos(bit_pos), .ctrl_bad(ctrl_bad)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // 40 transactions of up to 156 ticks, doubled, rounded up
    initial begin
        #3_000_000;
        $display("timeout: the tests did not finish within 3 ms");
        $display("Simulation failed");
        $finish;
    end

    task automatic report_fail(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic expect_true(input bit ok, input string msg);
        assert (ok) else report_fail(msg);
    endtask

    // bus rules, sampled on the clock
    assert property (@(posedge CLK) disable iff (RESET)
        scl && $past(scl) && !$stable(sda) |-> $past(bit_pos) <= 4'd1)
        else report_fail("SDA changed while SCL high inside a byte");
    assert property (@(posedge CLK) disable iff (RESET)
        $rose(scl) |=> scl ##1 scl ##1 scl ##1 (!scl || sda))
        else report_fail("SCL high phase is not 4 cycles");
    assert property (@(posedge CLK) disable iff (RESET)
        $fell(scl) |=> !scl ##1 !scl ##1 !scl)
        else report_fail("SCL low phase shorter than 4 cycles");
    assert property (@(posedge CLK) disable iff (RESET)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else report_fail("bvalid dropped before bready");
    assert property (@(posedge CLK) disable iff (RESET)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
        else report_fail("rvalid dropped before rready");
    assert property (@(posedge CLK) disable iff (RESET) !$rose(ctrl_bad))
        else report_fail("control byte does not carry the device select");

    task automatic axi_write(input logic [31:0] waddr, input logic [31:0] wdata,
                             output logic [1:0] bresp);
        @(posedge CLK);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= waddr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= wdata;
        axil_req.wstrb   <= 4'hf;
        @(negedge CLK);
        while (!axil_rsp.awready) @(negedge CLK);
        @(posedge CLK);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        @(negedge CLK);
        while (!axil_rsp.bvalid) @(negedge CLK);
        bresp = axil_rsp.bresp;
        repeat ($urandom_range(2)) @(posedge CLK);  // hold off bready a little
        @(posedge CLK);
        axil_req.bready <= 1'b1;
        @(posedge CLK);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] raddr, output logic [31:0] rd,
                            output logic [1:0] rresp);
        @(posedge CLK);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= raddr;
        @(negedge CLK);
        while (!axil_rsp.arready) @(negedge CLK);
        @(posedge CLK);
        axil_req.arvalid <= 1'b0;
        @(negedge CLK);
        while (!axil_rsp.rvalid) @(negedge CLK);
        rd    = axil_rsp.rdata;
        rresp = axil_rsp.rresp;
        repeat ($urandom_range(2)) @(posedge CLK);
        @(posedge CLK);
        axil_req.rready <= 1'b1;
        @(posedge CLK);
        axil_req.rready <= 1'b0;
    endtask

    // command word has bit 31 read, 18:11 data, 10:0 address
    function automatic logic [31:0] write_word(logic [ADDR_W-1:0] a, logic [7:0] d);
        return {1'b0, 12'd0, d, a};
    endfunction

    function automatic logic [31:0] read_word(logic [ADDR_W-1:0] a);
        return {1'b1, 12'd0, 8'd0, a};
    endfunction

    task automatic wait_idle(output logic [31:0] st);
        logic [1:0] r;
        st = 32'h1;
        while (st[0]) axi_read(ADDR_STATUS, st, r);
    endtask

    task automatic run_command(input logic [31:0] word, output logic [31:0] st);
        logic [1:0] r;
        axi_write(ADDR_CMD, word, r);
        expect_true(r == RESP_OKAY, $sformatf("command answered %b, expected OKAY", r));
        wait_idle(st);
    endtask

    task automatic expect_read(input logic [ADDR_W-1:0] a, input logic [31:0] st);
        expect_true(st[1:0] == 2'b00, $sformatf("read of %h left status %h", a, st));
        expect_true(st[15:8] == shadow[a],
                    $sformatf("read %h returned %h, expected %h", a, st[15:8], shadow[a]));
    endtask

    task automatic close_test(input string name);
        test_count++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", test_count, name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    initial begin
        void'($urandom(19682));
        RESET         = 1'b1;
        axil_req      = '0;
        present       = 1'b1;
        errors        = 0;
        errors_before = 0;
        test_count    = 0;
        tests_failed  = 0;
        repeat (16) @(posedge CLK);
        RESET <= 1'b0;

        @(negedge CLK);
        expect_true(scl === 1'b1 && sda === 1'b1, "bus not released after reset");
        axi_read(ADDR_STATUS, rdata, resp);
        expect_true(resp == RESP_OKAY && rdata == 32'h0,
                    $sformatf("status after reset %h with %b, expected 0", rdata, resp));
        close_test("reset state");

        addr = ADDR_W'($urandom_range(2047));
        data = 8'($urandom);
        run_command(write_word(addr, data), status);
        shadow[addr] = data;
        expect_true(status[1:0] == 2'b00, $sformatf("write left status %h", status));
        run_command(read_word(addr), status);
        expect_read(addr, status);
        close_test("write then read back");

        for (int i = 0; i < 16; i++) begin
            addrs[i] = {3'(i % 8), 8'($urandom)};  // two passes over the 8 blocks
            data     = 8'($urandom);
            run_command(write_word(addrs[i], data), status);
            shadow[addrs[i]] = data;
            expect_true(seen_addr == addrs[i],
                        $sformatf("slave saw %h, expected %h", seen_addr, addrs[i]));
        end
        for (int i = 0; i < 16; i++) begin
            run_command(read_word(addrs[i]), status);
            expect_true(seen_addr == addrs[i],
                        $sformatf("slave saw %h, expected %h", seen_addr, addrs[i]));
            expect_read(addrs[i], status);
        end
        close_test("address blocks");

        @(posedge CLK);
        present <= 1'b0;
        run_command(write_word(addr, ~data), status);
        expect_true(status[1:0] == 2'b10, $sformatf("nacked write status %h", status));
        expect_true(scl === 1'b1 && sda === 1'b1, "bus not released after nack stop");
        run_command(read_word(addr), status);
        expect_true(status[1:0] == 2'b10, $sformatf("nacked read status %h", status));
        @(posedge CLK);
        present <= 1'b1;
        run_command(read_word(addr), status);
        expect_read(addr, status);
        close_test("no-acknowledge");

        addr = ADDR_W'($urandom_range(2047));
        data = 8'($urandom);
        axi_write(ADDR_CMD, write_word(addr, data), resp);
        expect_true(resp == RESP_OKAY, $sformatf("first command answered %b", resp));
        axi_write(ADDR_CMD, write_word(~addr, ~data), resp);
        expect_true(resp == RESP_SLVERR, $sformatf("command while busy answered %b", resp));
        axi_read(ADDR_CMD, rdata, resp);
        expect_true(resp == RESP_OKAY && rdata == write_word(addr, data),
                    $sformatf("command register read %h with %b", rdata, resp));
        wait_idle(status);
        shadow[addr] = data;
        expect_true(status[1:0] == 2'b00, $sformatf("running write status %h", status));
        expect_true(seen_addr == addr, $sformatf("slave saw %h, expected %h", seen_addr, addr));
        run_command(read_word(addr), status);
        expect_read(addr, status);
        axi_write(32'h8, 32'h0, resp);
        expect_true(resp == RESP_SLVERR, $sformatf("unmapped write answered %b", resp));
        axi_read(32'hc, rdata, resp);
        expect_true(resp == RESP_SLVERR && rdata == 32'h0,
                    $sformatf("unmapped read answered %b with %h", resp, rdata));
        close_test("command while busy");

        $display("%0d tests passed, %0d tests failed", test_count - tests_failed,
                 tests_failed);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
eeprom_pkg.sv
scl_phase_timer.sv
i2c_bit_engine.sv
eeprom_seq_fsm.sv
axil_eeprom_regs.sv
eeprom_i2c_top.sv
eeprom_bus_model.sv
tb_eeprom_i2c.sv

// File: Bender.yml
package:
  name: eeprom_i2c

sources:
  - eeprom_pkg.sv
  - scl_phase_timer.sv
  - i2c_bit_engine.sv
  - eeprom_seq_fsm.sv
  - axil_eeprom_regs.sv
  - eeprom_i2c_top.sv
  - target: test
    files:
      - eeprom_bus_model.sv
      - tb_eeprom_i2c.sv
